// File: pixel_out.sv
module pixel_out (
  input  logic       clk_dot4x,
  input  logic       rst_n,
  input  logic       in_blank,
  input  logic       in_window,     // inside the display window
  input  logic [3:0] border_color,
  input  logic [3:0] bg_color,
  output logic [1:0] red,           // to the cxa1545p
  output logic [1:0] green,
  output logic [1:0] blue
);

  logic [3:0] color_idx;
  logic [5:0] rgb;

  // blank beats window and window beats border
  always_comb begin
    if (in_blank) begin
      color_idx = 4'd0;          // black, keeps sync clean
    end else if (in_window) begin
      color_idx = bg_color;
    end else begin
      color_idx = border_color;
    end
  end

  assign rgb = video_timing_pkg::palette[color_idx];

  // one clock behind the flags
  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      red   <= 2'd0;
      green <= 2'd0;
      blue  <= 2'd0;
    end else begin
      red   <= rgb[5:4];
      green <= rgb[3:2];
      blue  <= rgb[1:0];
    end
  end

endmodule : pixel_out

// File: raster_timing.sv
module raster_timing (
  input  logic       clk_dot4x,
  input  logic       rst_n,
  input  logic [1:0] chip,        // held steady outside reset
  output logic       dot_en,      // one clock in four
  output logic       clk_phi,
  output logic       phi_fall,    // clk_phi drops at the end of this clock
  output logic [9:0] raster_x,
  output logic [8:0] raster_y,
  output logic       line_start,  // first clock of a new line
  output logic       csync,
  output logic       in_blank,
  output logic       in_window
);

  logic [1:0] clk_cnt;        // position inside a dot
  logic [2:0] dot_in_cycle;
  logic [9:0] x_last;
  logic [8:0] y_last;
  logic       x_wrap;
  logic       hsync;
  logic       vsync;

  // line and frame ends from the chip tables
  assign x_last = 10'(video_timing_pkg::cycles_per_line[chip]
                      * video_timing_pkg::dots_per_cycle - 1);
  assign y_last = video_timing_pkg::lines_per_frame[chip] - 9'd1;

  assign dot_en       = (clk_cnt == 2'(video_timing_pkg::clks_per_dot - 1));
  assign dot_in_cycle = raster_x[2:0];          // lines are whole cycles long
  assign x_wrap       = dot_en && (raster_x == x_last);

  // phi high on dots 4..7
  assign clk_phi  = dot_in_cycle[2];
  assign phi_fall = dot_en && (dot_in_cycle == 3'd7);

  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      clk_cnt    <= '0;
      raster_x   <= '0;
      raster_y   <= '0;
      line_start <= 1'b0;
    end else begin
      clk_cnt    <= dot_en ? 2'd0 : clk_cnt + 2'd1;
      line_start <= x_wrap;
      if (dot_en) begin
        raster_x <= x_wrap ? 10'd0 : raster_x + 10'd1;
      end
      if (x_wrap) begin
        raster_y <= (raster_y == y_last) ? 9'd0 : raster_y + 9'd1;
      end
    end
  end

  assign hsync = (raster_x >= video_timing_pkg::hsync_start)
              && (raster_x <  video_timing_pkg::hsync_start + video_timing_pkg::hsync_len);
  assign vsync = (raster_y < video_timing_pkg::vsync_lines);

  // flags registered together so they stay aligned to each other
  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      csync     <= 1'b1;
      in_blank  <= 1'b1;
      in_window <= 1'b0;
    end else begin
      csync    <= vsync ? hsync : ~hsync;   // serrated during vsync
      in_blank <= (raster_x >= video_timing_pkg::hblank_start)
               || (raster_y <  video_timing_pkg::vblank_end);
      in_window <= (raster_x >= video_timing_pkg::win_x_first)
                && (raster_x <= video_timing_pkg::win_x_last)
                && (raster_y >= video_timing_pkg::win_y_first)
                && (raster_y <= video_timing_pkg::win_y_last);
    end
  end

  a_y_in_frame : assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    raster_y < video_timing_pkg::lines_per_frame[chip])
    else $error("raster_y past end of frame");

endmodule : raster_timing

// File: vic_bus_if.sv
module vic_bus_if (
  input  logic                               clk_dot4x,
  input  logic                               rst_n,
  input  logic                               clk_phi,   // cpu owns the bus while high
  input  logic                               phi_fall,  // last clock of phi high
  input  logic                               ce,        // low selects the chip
  input  logic                               rw,        // high read, low write
  input  logic [vic_reg_pkg::reg_addr_w-1:0] adl,
  input  logic [vic_reg_pkg::reg_data_w-1:0] db_in,
  output logic                               reg_wr,     // one clock after phi_fall
  output logic [vic_reg_pkg::reg_addr_w-1:0] reg_addr,
  output logic [vic_reg_pkg::reg_data_w-1:0] reg_wdata,
  output logic                               rd_en,
  output logic                               ls245_oe,   // low enables transceiver
  output logic                               ls245_dir   // high drives toward cpu
);

  logic                               ce_q;    // ce seen during phi high
  logic                               rw_q;
  logic [vic_reg_pkg::reg_addr_w-1:0] addr_q;  // address held through phi low
  logic                               cpu_sel;

  assign cpu_sel = clk_phi & ~ce;

  // control sampling, only tracks the pins in the cpu half
  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      ce_q <= 1'b1;
      rw_q <= 1'b1;
    end else if (clk_phi) begin
      ce_q <= ce;
      rw_q <= rw;
    end
  end

  // address and write data
  always_ff @(posedge clk_dot4x) begin
    if (clk_phi) begin
      addr_q <= adl;       // last load happens on the phi_fall clock
    end
    if (phi_fall) begin
      reg_wdata <= db_in;  // cpu still drives db here
    end
  end

  // a write selected during phi high becomes one strobe
  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      reg_wr <= 1'b0;
    end else begin
      reg_wr <= phi_fall & ~ce_q & ~rw_q;
    end
  end

  // live address in phi high so read data settles within a clock
  assign reg_addr = clk_phi ? adl : addr_q;

  assign rd_en     = cpu_sel & rw;
  assign ls245_oe  = ~cpu_sel;
  assign ls245_dir = rd_en;   // turn the ls245 around only for reads

  // strobe sits in phi low while reads only exist in phi high
  a_wr_not_rd : assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    !(reg_wr && rd_en))
    else $error("reg_wr overlaps rd_en");

endmodule : vic_bus_if

// File: vic_reg_pkg.sv
package vic_reg_pkg;

  // cpu side widths
  localparam int reg_addr_w = 6;   // adl pins
  localparam int reg_data_w = 8;   // data byte seen by the cpu
  localparam int db_w       = 12;  // full db pin count
  localparam int color_w    = 4;   // colour index width

  // register map
  localparam logic [reg_addr_w-1:0] addr_ctrl1      = 6'h11;
  localparam logic [reg_addr_w-1:0] addr_raster     = 6'h12;  // current line on read
  localparam logic [reg_addr_w-1:0] addr_irq_status = 6'h19;
  localparam logic [reg_addr_w-1:0] addr_irq_enable = 6'h1A;
  localparam logic [reg_addr_w-1:0] addr_border     = 6'h20;
  localparam logic [reg_addr_w-1:0] addr_background = 6'h21;

  // field positions
  localparam int ctrl1_rst8_bit = 7;  // raster bit 8 lives in ctrl1
  localparam int irq_rst_bit    = 0;  // raster irq in status and enable
  localparam int irq_any_bit    = 7;  // set while an enabled irq is pending

  // value read from an address the core does not implement
  localparam logic [reg_data_w-1:0] unused_read = 8'hFF;

  // bits that are not backed by storage come back as ones
  localparam logic [reg_data_w-1:0] ctrl1_rd_fill      = 8'h7F;
  localparam logic [reg_data_w-1:0] irq_status_rd_fill = 8'h7E;  // bits 6..1
  localparam logic [reg_data_w-1:0] irq_enable_rd_fill = 8'hFE;  // bits 7..1
  localparam logic [reg_data_w-1:0] color_rd_fill      = 8'hF0;  // upper nibble

  // db[11:8] are never driven by the cpu path so they read high
  localparam logic [db_w-reg_data_w-1:0] db_high_fill = '1;

endpackage : vic_reg_pkg

// File: vic_registers.sv
module vic_registers (
  input  logic                                clk_dot4x,
  input  logic                                rst_n,
  input  logic                                reg_wr,
  input  logic [vic_reg_pkg::reg_addr_w-1:0]  reg_addr,
  input  logic [vic_reg_pkg::reg_data_w-1:0]  reg_wdata,
  input  logic [8:0]                          raster_y,    // already the new line at line_start
  input  logic                                line_start,
  output logic [vic_reg_pkg::reg_data_w-1:0]  rdata,
  output logic [vic_reg_pkg::color_w-1:0]     border_color,
  output logic [vic_reg_pkg::color_w-1:0]     bg_color,
  output logic                                irq          // active low
);

  logic [8:0] raster_cmp;   // compare line
  logic       irq_status;   // raster irq latch
  logic       irq_enable;
  logic       status_nxt;
  logic       enable_nxt;
  logic       wr_status;
  logic       wr_enable;
  logic       cmp_hit;

  assign wr_status = reg_wr && (reg_addr == vic_reg_pkg::addr_irq_status);
  assign wr_enable = reg_wr && (reg_addr == vic_reg_pkg::addr_irq_enable);
  assign cmp_hit   = line_start && (raster_y == raster_cmp);

  // next irq state, shared by the latch and the pin register
  always_comb begin
    status_nxt = irq_status;
    enable_nxt = irq_enable;
    if (wr_status && reg_wdata[vic_reg_pkg::irq_rst_bit]) begin
      status_nxt = 1'b0;       // write one to acknowledge
    end
    if (cmp_hit) begin
      status_nxt = 1'b1;       // a new match wins over a same clock ack
    end
    if (wr_enable) begin
      enable_nxt = reg_wdata[vic_reg_pkg::irq_rst_bit];
    end
  end

  always_ff @(posedge clk_dot4x) begin
    if (!rst_n) begin
      irq_status   <= 1'b0;
      irq_enable   <= 1'b0;
      irq          <= 1'b1;
      raster_cmp   <= '0;
      border_color <= '0;
      bg_color     <= '0;
    end else begin
      irq_status <= status_nxt;
      irq_enable <= enable_nxt;
      irq        <= ~(status_nxt & enable_nxt);   // pin moves with the latch
      if (reg_wr) begin
        case (reg_addr)
          vic_reg_pkg::addr_ctrl1:      raster_cmp[8]   <= reg_wdata[vic_reg_pkg::ctrl1_rst8_bit];
          vic_reg_pkg::addr_raster:     raster_cmp[7:0] <= reg_wdata;
          vic_reg_pkg::addr_border:     border_color    <= reg_wdata[vic_reg_pkg::color_w-1:0];
          vic_reg_pkg::addr_background: bg_color        <= reg_wdata[vic_reg_pkg::color_w-1:0];
          default: ;  // status and enable handled above
        endcase
      end
    end
  end

  // read mux, registered so db is steady for the phi high half
  always_ff @(posedge clk_dot4x) begin
    case (reg_addr)
      vic_reg_pkg::addr_ctrl1:
        rdata <= vic_reg_pkg::ctrl1_rd_fill | {raster_y[8], 7'd0};
      vic_reg_pkg::addr_raster:
        rdata <= raster_y[7:0];   // reads the beam, not the compare value
      vic_reg_pkg::addr_irq_status:
        rdata <= vic_reg_pkg::irq_status_rd_fill
               | {irq_status & irq_enable, 6'd0, irq_status};
      vic_reg_pkg::addr_irq_enable:
        rdata <= vic_reg_pkg::irq_enable_rd_fill | {7'd0, irq_enable};
      vic_reg_pkg::addr_border:
        rdata <= vic_reg_pkg::color_rd_fill | {4'd0, border_color};
      vic_reg_pkg::addr_background:
        rdata <= vic_reg_pkg::color_rd_fill | {4'd0, bg_color};
      default:
        rdata <= vic_reg_pkg::unused_read;
    endcase
  end

  // pin low must mean a pending enabled raster irq
  a_irq_cause : assert property (@(posedge clk_dot4x) disable iff (!rst_n)
    !irq |-> (irq_status && irq_enable))
    else $error("irq low without enabled status");

endmodule : vic_registers

// File: vicii_top.f
+incdir+.
vic_reg_pkg.sv
video_timing_pkg.sv
vic_bus_if.sv
vic_registers.sv
raster_timing.sv
pixel_out.sv
vicii_top.sv
vicii_top_tb.sv

// File: vicii_top.sv
module vicii_top (
  input  logic       clk_dot4x,
  input  logic       rst_n,
  input  logic [1:0] chip,       // video standard select
  input  logic [5:0] adl,        // register address from the cpu
  inout  tri   [11:0] db,
  input  logic       ce,         // low enables
  input  logic       rw,         // low writes
  output logic       clk_phi,    // cpu clock
  output logic       csync,
  output logic [1:0] red,
  output logic [1:0] green,
  output logic [1:0] blue,
  output logic       irq,
  output logic       ls245_oe,
  output logic       ls245_dir
);

  logic                               phi_fall;
  logic [8:0]                         raster_y;
  logic                               line_start;
  logic                               in_blank;
  logic                               in_window;
  logic                               reg_wr;
  logic [vic_reg_pkg::reg_addr_w-1:0] reg_addr;
  logic [vic_reg_pkg::reg_data_w-1:0] reg_wdata;
  logic [vic_reg_pkg::reg_data_w-1:0] rdata;
  logic                               rd_en;
  logic [vic_reg_pkg::color_w-1:0]    border_color;
  logic [vic_reg_pkg::color_w-1:0]    bg_color;

  raster_timing u_timing (
    .clk_dot4x  (clk_dot4x),
    .rst_n      (rst_n),
    .chip       (chip),
    .dot_en     (),            // only used inside the timing block
    .clk_phi    (clk_phi),
    .phi_fall   (phi_fall),
    .raster_x   (),
    .raster_y   (raster_y),
    .line_start (line_start),
    .csync      (csync),
    .in_blank   (in_blank),
    .in_window  (in_window)
  );

  vic_bus_if u_bus (
    .clk_dot4x (clk_dot4x),
    .rst_n     (rst_n),
    .clk_phi   (clk_phi),
    .phi_fall  (phi_fall),
    .ce        (ce),
    .rw        (rw),
    .adl       (adl),
    .db_in     (db[vic_reg_pkg::reg_data_w-1:0]),  // cpu only writes the low byte
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .rd_en     (rd_en),
    .ls245_oe  (ls245_oe),
    .ls245_dir (ls245_dir)
  );

  vic_registers u_regs (
    .clk_dot4x    (clk_dot4x),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .raster_y     (raster_y),
    .line_start   (line_start),
    .rdata        (rdata),
    .border_color (border_color),
    .bg_color     (bg_color),
    .irq          (irq)
  );

  pixel_out u_pixel (
    .clk_dot4x    (clk_dot4x),
    .rst_n        (rst_n),
    .in_blank     (in_blank),
    .in_window    (in_window),
    .border_color (border_color),
    .bg_color     (bg_color),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  // drive db only for a cpu read, otherwise release it
  assign db = rd_en ? {vic_reg_pkg::db_high_fill, rdata} : 'z;

endmodule : vicii_top

// File: vicii_tb_model.svh
`ifndef vicii_tb_model_svh
`define vicii_tb_model_svh

  // {r, g, b} per colour index, 2 bits each as the cxa1545p gets them
  localparam logic [5:0] tb_palette [16] = '{
    6'b000000, 6'b111111, 6'b100000, 6'b011111,
    6'b100010, 6'b001000, 6'b000010, 6'b111101,
    6'b100100, 6'b010100, 6'b110101, 6'b010101,
    6'b101010, 6'b011101, 6'b010111, 6'b111011
  };
  localparam int tb_cycles [3] = '{63, 65, 64};    // pal, r8, r56a
  localparam int tb_lines  [3] = '{312, 263, 262};

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // expected db for a cpu read, upper nibble of db always high
  function automatic logic [11:0] ref_read(input logic [5:0] addr);
    logic [7:0] v;
    case (addr)
      vic_reg_pkg::addr_ctrl1:      v = {shadow_line[8], 7'h7F};
      vic_reg_pkg::addr_raster:     v = shadow_line[7:0];
      vic_reg_pkg::addr_irq_status: v = {shadow_status & shadow_en, 6'h3F, shadow_status};
      vic_reg_pkg::addr_irq_enable: v = {7'h7F, shadow_en};
      vic_reg_pkg::addr_border:     v = {4'hF, shadow_border};
      vic_reg_pkg::addr_background: v = {4'hF, shadow_bg};
      default:                      v = 8'hFF;   // nothing behind it
    endcase
    return {4'hF, v};
  endfunction

  function automatic int frame_clocks(input logic [1:0] sel);
    return tb_cycles[sel] * 8 * tb_lines[sel] * 4;   // 8 dots a cycle, 4 clocks a dot
  endfunction

  function automatic int line_clocks(input logic [1:0] sel);
    return tb_cycles[sel] * 32;
  endfunction

  function automatic logic [5:0] expected_rgb(input logic [3:0] idx);
    return tb_palette[idx];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "%s mismatch", name);
    end
  endtask

`endif

// File: vicii_top_tb.sv
module vicii_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk_dot4x = 1'b0;
  logic        rst_n;
  logic [1:0]  chip;
  logic [5:0]  adl;
  logic        ce;
  logic        rw;
  tri   [11:0] db;
  logic [11:0] db_drv;     // cpu side of db
  logic        db_oe;
  logic        clk_phi;
  logic        csync;
  logic [1:0]  red;
  logic [1:0]  green;
  logic [1:0]  blue;
  logic        irq;
  logic        ls245_oe;
  logic        ls245_dir;

  // shadow of the cpu writes
  logic [3:0]  shadow_border;
  logic [3:0]  shadow_bg;
  logic [8:0]  shadow_line;  // compare line
  logic        shadow_status;
  logic        shadow_en;

  logic [15:0] lfsr_state = 16'd47;
  int          err_count  = 0;
  int          cyc        = 0;     // clocks since start
  int          watch_left = 0;     // clocks left to scan after an irq
  int          sync_clks  = 0;     // csync low clocks on the scanned line
  logic        armed      = 1'b0;  // irq falls now mark the compare line
  logic        irq_prev   = 1'b1;
  logic        seen_border;
  logic        seen_bg;

  localparam logic [5:0] readback_addrs [6] = '{vic_reg_pkg::addr_border,
    vic_reg_pkg::addr_background, vic_reg_pkg::addr_irq_enable, 6'h00, 6'h2E, 6'h3F};

  `include "vicii_tb_model.svh"

  vicii_top uut (
    .clk_dot4x (clk_dot4x), .rst_n (rst_n), .chip (chip), .adl (adl), .db (db),
    .ce (ce), .rw (rw), .clk_phi (clk_phi), .csync (csync),
    .red (red), .green (green), .blue (blue), .irq (irq),
    .ls245_oe (ls245_oe), .ls245_dir (ls245_dir)
  );

  assign db = db_oe ? db_drv : 'z;

  always #50 clk_dot4x = ~clk_dot4x;
  always @(posedge clk_dot4x) cyc <= cyc + 1;

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  endtask

  task automatic wait_phi(input logic level);
    int n;
    n = 0;
    @(negedge clk_dot4x);
    while (clk_phi !== level) begin
      if (n == 64) timeout_fail("a clk_phi edge");   // two phi periods
      n++;
      @(negedge clk_dot4x);
    end
  endtask

  task automatic wait_irq(input logic level, input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk_dot4x);
    while (irq !== level) begin
      if (n >= limit) timeout_fail(what);
      n++;
      @(negedge clk_dot4x);
    end
  endtask

  task automatic wait_watch_done();
    int n;
    n = 0;
    while (watch_left != 0) begin
      if (n == 4096) timeout_fail("the end of the compare line scan");
      n++;
      @(negedge clk_dot4x);
    end
  endtask

  task automatic apply_reset(input logic [1:0] sel);
    @(posedge clk_dot4x);
    rst_n <= 1'b0;
    chip  <= sel;
    ce    <= 1'b1;
    rw    <= 1'b1;
    db_oe <= 1'b0;
    repeat (5) @(posedge clk_dot4x);
    rst_n <= 1'b1;
    shadow_border = '0;
    shadow_bg     = '0;
    shadow_line   = '0;
    shadow_status = 1'b0;
    shadow_en     = 1'b0;
  endtask

  // set up in phi low, hold through one whole phi high
  task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
    wait_phi(1'b0);
    @(posedge clk_dot4x);
    ce     <= 1'b0;
    rw     <= 1'b0;
    adl    <= addr;
    db_drv <= {4'hF, data};
    db_oe  <= 1'b1;
    wait_phi(1'b1);
    wait_phi(1'b0);          // db taken at phi_fall
    @(posedge clk_dot4x);
    ce    <= 1'b1;
    rw    <= 1'b1;
    db_oe <= 1'b0;
  endtask

  task automatic bus_read(input logic [5:0] addr, output logic [11:0] data);
    wait_phi(1'b0);
    @(posedge clk_dot4x);
    ce  <= 1'b0;
    rw  <= 1'b1;
    adl <= addr;
    wait_phi(1'b1);
    @(negedge clk_dot4x);    // rdata now from the live address
    data = db;
    check_value("ls245_oe", ls245_oe, 1'b0);
    check_value("ls245_dir", ls245_dir, 1'b1);
    wait_phi(1'b0);
    @(posedge clk_dot4x);
    ce <= 1'b1;
  endtask

  // sync keeps rgb black, compare line shows only border and background
  always @(negedge clk_dot4x) begin
    if (rst_n) begin
      if (csync === 1'b0) begin
        check_value("rgb in sync", {red, green, blue}, 6'd0);
      end
      if (watch_left > 0) begin
        if (csync === 1'b0) begin
          sync_clks = sync_clks + 1;   // hsync still runs on the compare line
        end
        if ({red, green, blue} == expected_rgb(shadow_border)) begin
          seen_border = 1'b1;
        end else if ({red, green, blue} == expected_rgb(shadow_bg)) begin
          seen_bg = 1'b1;
        end else if ({red, green, blue} != 6'd0) begin
          check_value("rgb on compare line", {red, green, blue}, expected_rgb(shadow_border));
        end
        watch_left = watch_left - 1;
        if (watch_left == 0) begin
          check_value("border and background seen", {seen_border, seen_bg}, 2'b11);
          check_value("csync low clocks", sync_clks,
                      video_timing_pkg::hsync_len * video_timing_pkg::clks_per_dot);
        end
      end else if (armed && irq_prev && !irq) begin
        watch_left  = line_clocks(chip);
        seen_border = 1'b0;
        seen_bg     = 1'b0;
        sync_clks   = 0;
      end
      irq_prev = irq;
    end
  end

  initial begin
    logic [11:0] rd;
    logic [7:0]  val;
    int          t_fall;
    int          t_phi;
    rst_n  = 1'b0;
    chip   = video_timing_pkg::chip_pal;
    adl    = '0;
    ce     = 1'b1;
    rw     = 1'b1;
    db_drv = '0;
    db_oe  = 1'b0;
    for (int k = 0; k < 2; k++) begin
      apply_reset(k == 0 ? video_timing_pkg::chip_pal : video_timing_pkg::chip_ntsc_r8);
      @(negedge clk_dot4x);
      check_value("irq", irq, 1'b1);
      check_value("ls245_oe", ls245_oe, 1'b1);
      check_value("ls245_dir", ls245_dir, 1'b0);
      // phi high for four dots out of eight
      wait_phi(1'b1);
      t_phi = cyc;
      wait_phi(1'b0);
      check_value("clk_phi high clocks", cyc - t_phi, 16);
      wait_phi(1'b1);
      check_value("clk_phi period", cyc - t_phi, 32);
      // colours nonzero and distinct so both show up on screen
      shadow_border = 4'(take_bits(4));
      if (shadow_border == 4'd0) shadow_border = 4'd1;
      shadow_bg = 4'(take_bits(4));
      while (shadow_bg == 4'd0 || shadow_bg == shadow_border) begin
        shadow_bg = 4'(take_bits(4));
      end
      val       = take_bits(8);
      shadow_en = val[0];
      bus_write(vic_reg_pkg::addr_border, {4'h0, shadow_border});
      bus_write(vic_reg_pkg::addr_background, {4'h0, shadow_bg});
      bus_write(vic_reg_pkg::addr_irq_enable, val);
      foreach (readback_addrs[i]) begin
        bus_read(readback_addrs[i], rd);
        check_value($sformatf("db at %h", readback_addrs[i]), rd, ref_read(readback_addrs[i]));
      end
      // raster irq on a line inside the window
      shadow_line = 9'(51 + take_bits(8) % 200);
      bus_write(vic_reg_pkg::addr_raster, shadow_line[7:0]);
      bus_write(vic_reg_pkg::addr_ctrl1, {shadow_line[8], 7'h00});
      bus_write(vic_reg_pkg::addr_irq_status, 8'h01);   // drop any stale status
      shadow_status = 1'b0;
      wait_irq(1'b1, 64, "irq release after acknowledge");
      armed = 1'b1;
      bus_write(vic_reg_pkg::addr_irq_enable, 8'h01);
      shadow_en = 1'b1;
      wait_irq(1'b0, frame_clocks(chip) + 64, "the first raster irq");
      t_fall        = cyc;
      shadow_status = 1'b1;
      bus_read(vic_reg_pkg::addr_raster, rd);
      check_value("db raster", rd, ref_read(vic_reg_pkg::addr_raster));
      bus_read(vic_reg_pkg::addr_irq_status, rd);
      check_value("db irq status", rd, ref_read(vic_reg_pkg::addr_irq_status));
      // acknowledge, pin back high by the next phi high
      bus_write(vic_reg_pkg::addr_irq_status, 8'h01);
      shadow_status = 1'b0;
      wait_phi(1'b1);
      check_value("irq after ack", irq, 1'b1);
      bus_read(vic_reg_pkg::addr_irq_status, rd);
      check_value("db irq status", rd, ref_read(vic_reg_pkg::addr_irq_status));
      // next fall one frame later
      wait_irq(1'b0, frame_clocks(chip) + 64, "the second raster irq");
      check_value("clocks between irqs", cyc - t_fall, frame_clocks(chip));
      bus_write(vic_reg_pkg::addr_irq_status, 8'h01);
      shadow_status = 1'b0;
      wait_watch_done();
      armed = 1'b0;
    end
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : vicii_top_tb

// File: video_timing_pkg.sv
package video_timing_pkg;

  // chip select encoding
  localparam logic [1:0] chip_pal       = 2'd0;  // 6569
  localparam logic [1:0] chip_ntsc_r8   = 2'd1;  // 6567R8
  localparam logic [1:0] chip_ntsc_r56a = 2'd2;  // 6567R56A

  // per chip geometry, the spare code 3 falls back to pal numbers
  localparam logic [6:0] cycles_per_line [4] = '{7'd63, 7'd65, 7'd64, 7'd63};
  localparam logic [8:0] lines_per_frame [4] = '{9'd312, 9'd263, 9'd262, 9'd312};

  localparam int unsigned dots_per_cycle = 8;  // pixels per phi period
  localparam int unsigned clks_per_dot   = 4;  // clk_dot4x ticks per pixel

  // horizontal sync in dots, fits inside the shortest (504 dot) line
  localparam logic [9:0] hsync_start = 10'd416;
  localparam logic [9:0] hsync_len   = 10'd38;

  // vertical sync covers the first lines of the frame
  localparam logic [8:0] vsync_lines = 9'd3;

  // blanking, hblank runs to end of line
  localparam logic [9:0] hblank_start = 10'd376;
  localparam logic [8:0] vblank_end   = 9'd16;   // lines below this are blank

  // display window, inclusive bounds
  localparam logic [9:0] win_x_first = 10'd24;
  localparam logic [9:0] win_x_last  = 10'd343;
  localparam logic [8:0] win_y_first = 9'd51;
  localparam logic [8:0] win_y_last  = 9'd250;

  // colour index to {r, g, b}, 2 bits each for the cxa1545p
  localparam logic [5:0] palette [16] = '{
    6'b00_00_00,  // black
    6'b11_11_11,  // white
    6'b10_00_00,  // red
    6'b01_11_11,  // cyan
    6'b10_00_10,  // purple
    6'b00_10_00,  // green
    6'b00_00_10,  // blue
    6'b11_11_01,  // yellow
    6'b10_01_00,  // orange
    6'b01_01_00,  // brown
    6'b11_01_01,  // light red
    6'b01_01_01,  // dark grey
    6'b10_10_10,  // mid grey
    6'b01_11_01,  // light green
    6'b01_01_11,  // light blue
    6'b11_10_11   // light grey
  };

endpackage : video_timing_pkg
